//--- verilog/mem_sys_pkg.sv
package mem_sys_pkg;

   // Data word and byte address share one width
   localparam int word_w = 16;

   // Address split: tag 15:11, index 10:3, byte offset 2:0
   localparam int tag_w = 5;
   localparam int index_w = 8;
   localparam int offset_w = 3;

   // Cache geometry
   localparam int lines = 256;
   localparam int words_per_line = 4;

   // Memory timing, in clock cycles
   localparam int mem_read_latency = 2;
   // Busy window counts the access cycle itself
   localparam int bank_busy_cycles = 4;

   // Request to the banked memory
   typedef struct packed {
      logic [word_w-1:0] addr;
      logic [word_w-1:0] data;
      logic              rd;
      logic              wr;
   } mem_req_t;

   // Request to the cache array
   typedef struct packed {
      logic                en;
      logic                comp;
      logic                write;
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;
      logic [word_w-1:0]   data;
   } cache_req_t;

   // Response from the cache array
   typedef struct packed {
      logic              hit;
      logic              valid;
      logic              dirty;
      logic [tag_w-1:0]  tag_out;
      logic [word_w-1:0] data_out;
   } cache_rsp_t;

   // Miss handler states
   typedef enum logic [3:0] {
      idle, compare, check, probe_dirty,
      wb_1, wb_2, wb_3, wb_done,
      fill_1, fill_2, fill_3, fill_4, fill_5,
      retry, finish
   } ctrl_state_t;

endpackage

//--- verilog/cache_array.sv
module cache_array
   import mem_sys_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  cache_req_t req,
   output cache_rsp_t rsp,
   output logic       err
);

   // Per-line tag store
   logic [tag_w-1:0]  tag_mem [lines];
   // One word per entry, addressed by index and word offset
   logic [word_w-1:0] data_mem [lines*words_per_line];
   // Line status bits
   logic [lines-1:0]  valid_bits;
   logic [lines-1:0]  dirty_bits;

   logic [index_w+offset_w-2:0] word_idx;
   logic                        tag_eq;
   logic                        hit;
   logic                        comp_write;
   logic                        access_write;

   // Byte offset bit 0 does not select a word
   assign word_idx = {req.index, req.offset[offset_w-1:1]};
   assign tag_eq = tag_mem[req.index] == req.tag;

   // Hit only reported for an enabled compare
   assign hit = req.en & req.comp & valid_bits[req.index] & tag_eq;

   // Compare write lands only on a hit
   assign comp_write = req.en & req.write & req.comp & hit;
   // Access write always lands and claims the line
   assign access_write = req.en & req.write & ~req.comp;

   // Odd byte offset is a misaligned word access
   assign err = req.en & req.offset[0];

   // Reads are combinational
   always_comb begin
      rsp.hit = hit;
      rsp.valid = valid_bits[req.index];
      rsp.dirty = dirty_bits[req.index];
      rsp.tag_out = tag_mem[req.index];
      rsp.data_out = data_mem[word_idx];
   end

   // Word and tag storage
   always_ff @(posedge clk) begin
      if (comp_write || access_write) begin
         data_mem[word_idx] <= req.data;
      end
      if (access_write) begin
         tag_mem[req.index] <= req.tag;
      end
   end

   // Valid and dirty bits
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (access_write) begin
         // Fill word from memory leaves the line clean
         valid_bits[req.index] <= 1'b1;
         dirty_bits[req.index] <= 1'b0;
      end else if (comp_write) begin
         // Requester store makes the line differ from memory
         dirty_bits[req.index] <= 1'b1;
      end
   end

   // Controller only writes with the array enabled
   assert property (@(posedge clk) disable iff (reset) req.write |-> req.en);

endmodule

//--- verilog/four_bank_mem.sv
module four_bank_mem
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  mem_req_t          req,
   output logic [word_w-1:0] data,
   output logic              stall,
   output logic              err
);

   typedef logic [$clog2(bank_busy_cycles)-1:0] busy_t;

   // One bank per word of a line, 8K words each
   // Contents start at zero and survive reset
   logic [word_w-1:0] bank_mem [words_per_line][2**(word_w-offset_w)] = '{default: '0};

   // Remaining busy cycles per bank
   busy_t busy_cnt [words_per_line];
   logic [words_per_line-1:0] bank_busy;

   // Read data pipeline
   logic [word_w-1:0] rd_pipe [mem_read_latency];

   logic [offset_w-2:0]      bank_sel;
   logic [word_w-offset_w-1:0] row;
   logic                     strobe;
   logic                     accept;

   // Word address is addr 15:1, low two bits pick the bank
   assign bank_sel = req.addr[offset_w-1:1];
   assign row = req.addr[word_w-1:offset_w];

   always_comb begin
      for (int b = 0; b < words_per_line; b++) begin
         bank_busy[b] = busy_cnt[b] != '0;
      end
   end

   assign strobe = req.rd | req.wr;
   // Addressed bank still in its busy window
   assign stall = bank_busy[bank_sel];
   // Misaligned address or both strobes together
   assign err = strobe & (req.addr[0] | (req.rd & req.wr));
   // Access taken only by a free bank and a clean request
   assign accept = strobe & ~stall & ~err;

   // Busy window per bank
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < words_per_line; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < words_per_line; b++) begin
            if (accept && bank_sel == 2'(b)) begin
               // Access cycle counts as the first busy cycle
               busy_cnt[b] <= busy_t'(bank_busy_cycles - 1);
            end else if (bank_busy[b]) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Store on an accepted write
   always_ff @(posedge clk) begin
      if (accept && req.wr) begin
         bank_mem[bank_sel][row] <= req.data;
      end
   end

   // Read word enters stage 0, then shifts every cycle
   always_ff @(posedge clk) begin
      if (accept && req.rd) begin
         rd_pipe[0] <= bank_mem[bank_sel][row];
      end
      for (int i = 1; i < mem_read_latency; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   // Word appears mem_read_latency cycles after its strobe
   assign data = rd_pipe[mem_read_latency-1];

   // Controller never raises both strobes
   assert property (@(posedge clk) disable iff (reset) !(req.rd && req.wr));

endmodule

//--- verilog/cache_ctrl.sv
module cache_ctrl
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic [word_w-1:0] addr,
   input  logic [word_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [word_w-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err,
   output cache_req_t        cache_req,
   input  cache_rsp_t        cache_rsp,
   input  logic              cache_err,
   output mem_req_t          mem_req,
   input  logic [word_w-1:0] mem_data,
   input  logic              mem_stall,
   input  logic              mem_err
);

   ctrl_state_t state;
   ctrl_state_t next_state;

   // Request held for the whole access
   logic [word_w-1:0] req_addr;
   logic [word_w-1:0] req_data;
   logic              req_wr;

   // Results of the first compare
   logic              hit_q;
   logic              valid_q;
   logic              dirty_q;
   logic [tag_w-1:0]  tag_q;

   logic [tag_w-1:0]    req_tag;
   logic [index_w-1:0]  req_index;
   logic [offset_w-1:0] req_offset;
   // Line addresses without the offset
   logic [tag_w+index_w-1:0] fill_line;
   logic [tag_w+index_w-1:0] wb_line;

   assign req_tag = req_addr[word_w-1 -: tag_w];
   assign req_index = req_addr[offset_w +: index_w];
   assign req_offset = req_addr[offset_w-1:0];
   assign fill_line = {req_tag, req_index};
   // Victim line keeps its old tag
   assign wb_line = {tag_q, req_index};

   // Read data always comes from the array
   assign data_out = cache_rsp.data_out;
   assign err = cache_err | mem_err;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
      end else begin
         state <= next_state;
      end
   end

   // Capture the new request on entry to compare
   always_ff @(posedge clk) begin
      if (reset) begin
         req_wr <= 1'b0;
      end else if (next_state == compare) begin
         req_wr <= wr;
      end
   end

   always_ff @(posedge clk) begin
      if (next_state == compare) begin
         req_addr <= addr;
         req_data <= data_in;
      end
   end

   // Line status seen by the first compare
   always_ff @(posedge clk) begin
      if (reset) begin
         hit_q <= 1'b0;
         valid_q <= 1'b0;
         dirty_q <= 1'b0;
      end else if (state == compare) begin
         hit_q <= cache_rsp.hit;
         valid_q <= cache_rsp.valid;
         dirty_q <= cache_rsp.dirty;
      end
   end

   always_ff @(posedge clk) begin
      if (state == compare) begin
         tag_q <= cache_rsp.tag_out;
      end
   end

   always_comb begin
      next_state = state;
      done = 1'b0;
      cache_hit = 1'b0;
      // Busy in every state but a quiet idle and the done cycle
      stall = 1'b1;
      cache_req = '{en: 1'b0, comp: 1'b0, write: 1'b0, tag: req_tag,
                    index: req_index, offset: req_offset, data: req_data};
      // Writeback data is the array word read this cycle
      mem_req = '{addr: {fill_line, offset_w'(0)}, data: cache_rsp.data_out,
                  rd: 1'b0, wr: 1'b0};

      case (state)
         idle: begin
            stall = rd | wr;
            if (rd || wr) begin
               next_state = compare;
            end
         end

         // Lookup where a write hit also stores
         compare: begin
            cache_req.en = 1'b1;
            cache_req.comp = 1'b1;
            cache_req.write = req_wr;
            next_state = check;
         end

         check: begin
            if (hit_q) begin
               // Access read puts the word on data_out
               cache_req.en = 1'b1;
               done = 1'b1;
               cache_hit = 1'b1;
               stall = 1'b0;
               next_state = (rd || wr) ? compare : idle;
            end else begin
               next_state = probe_dirty;
            end
         end

         probe_dirty: begin
            if (valid_q && dirty_q) begin
               // First victim word goes out
               cache_req.en = 1'b1;
               cache_req.offset = offset_w'(0);
               mem_req.wr = 1'b1;
               mem_req.addr = {wb_line, offset_w'(0)};
               next_state = wb_1;
            end else begin
               // Clean victim goes straight to the fill
               mem_req.rd = 1'b1;
               next_state = fill_1;
            end
         end

         wb_1: begin
            cache_req.en = 1'b1;
            cache_req.offset = offset_w'(2);
            mem_req.wr = 1'b1;
            mem_req.addr = {wb_line, offset_w'(2)};
            next_state = wb_2;
         end

         wb_2: begin
            cache_req.en = 1'b1;
            cache_req.offset = offset_w'(4);
            mem_req.wr = 1'b1;
            mem_req.addr = {wb_line, offset_w'(4)};
            next_state = wb_3;
         end

         wb_3: begin
            cache_req.en = 1'b1;
            cache_req.offset = offset_w'(6);
            mem_req.wr = 1'b1;
            mem_req.addr = {wb_line, offset_w'(6)};
            next_state = wb_done;
         end

         // First fill read once bank 0 is free again
         wb_done: begin
            mem_req.rd = 1'b1;
            next_state = fill_1;
         end

         fill_1: begin
            mem_req.rd = 1'b1;
            mem_req.addr = {fill_line, offset_w'(2)};
            next_state = fill_2;
         end

         // Word 0 returns two cycles after its read
         fill_2: begin
            mem_req.rd = 1'b1;
            mem_req.addr = {fill_line, offset_w'(4)};
            cache_req.en = 1'b1;
            cache_req.write = 1'b1;
            cache_req.offset = offset_w'(0);
            cache_req.data = mem_data;
            next_state = fill_3;
         end

         fill_3: begin
            mem_req.rd = 1'b1;
            mem_req.addr = {fill_line, offset_w'(6)};
            cache_req.en = 1'b1;
            cache_req.write = 1'b1;
            cache_req.offset = offset_w'(2);
            cache_req.data = mem_data;
            next_state = fill_4;
         end

         fill_4: begin
            cache_req.en = 1'b1;
            cache_req.write = 1'b1;
            cache_req.offset = offset_w'(4);
            cache_req.data = mem_data;
            next_state = fill_5;
         end

         fill_5: begin
            cache_req.en = 1'b1;
            cache_req.write = 1'b1;
            cache_req.offset = offset_w'(6);
            cache_req.data = mem_data;
            next_state = retry;
         end

         // Line now present, redo the original access
         retry: begin
            cache_req.en = 1'b1;
            cache_req.comp = 1'b1;
            cache_req.write = req_wr;
            next_state = finish;
         end

         finish: begin
            cache_req.en = 1'b1;
            done = 1'b1;
            stall = 1'b0;
            next_state = (rd || wr) ? compare : idle;
         end

         default: begin
            next_state = idle;
         end
      endcase

      // Strobe waits while its bank is busy
      if ((mem_req.rd || mem_req.wr) && mem_stall) begin
         next_state = state;
      end
   end

   // Done is a single-cycle pulse
   assert property (@(posedge clk) disable iff (reset) done |=> !done);
   // Requester never sees done while stalled
   assert property (@(posedge clk) disable iff (reset) !(done && stall));

endmodule

//--- verilog/mem_system.sv
module mem_system
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic [word_w-1:0] addr,
   input  logic [word_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [word_w-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);

   // Controller to array
   cache_req_t        cache_req;
   cache_rsp_t        cache_rsp;
   logic              cache_err;

   // Controller to memory
   mem_req_t          mem_req;
   logic [word_w-1:0] mem_data;
   logic              mem_stall;
   logic              mem_err;

   // Miss handler and top-level status
   cache_ctrl cache_ctrl_i (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err),
      .cache_req (cache_req),
      .cache_rsp (cache_rsp),
      .cache_err (cache_err),
      .mem_req   (mem_req),
      .mem_data  (mem_data),
      .mem_stall (mem_stall),
      .mem_err   (mem_err)
   );

   // Direct-mapped store
   cache_array cache_array_i (
      .clk   (clk),
      .reset (reset),
      .req   (cache_req),
      .rsp   (cache_rsp),
      .err   (cache_err)
   );

   // Backing memory
   four_bank_mem four_bank_mem_i (
      .clk   (clk),
      .reset (reset),
      .req   (mem_req),
      .data  (mem_data),
      .stall (mem_stall),
      .err   (mem_err)
   );

endmodule

//--- test/mem_system_tb.sv
module mem_system_tb
   import mem_sys_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int clk_period = 4;
   // Longest wait for done on any single request
   localparam int done_limit = 30;
   localparam int random_requests = 200;
   // Directed requests plus random traffic
   localparam int num_requests = 18 + random_requests;

   logic              clk;
   logic              reset;
   logic [word_w-1:0] addr;
   logic [word_w-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [word_w-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   int     checks;
   int     errors;
   integer seed;

   // Reference model of memory as the requester sees it, plus line ownership
   logic [word_w-1:0] model_mem [logic [word_w-2:0]];
   logic [tag_w-1:0]  model_tag [lines];
   logic [lines-1:0]  model_valid;

   mem_system mem_system_i (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic compare_word(input string name, input logic [word_w-1:0] expected,
                               input logic [word_w-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic compare_bit(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      end
   endtask

   task automatic compare_cycles(input string name, input int expected, input int actual);
      checks++;
      if (actual != expected) begin
         errors++;
         $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   // Untouched words read as zero
   function automatic logic [word_w-1:0] model_word(input logic [word_w-2:0] waddr);
      if (model_mem.exists(waddr)) begin
         return model_mem[waddr];
      end
      return '0;
   endfunction

   task automatic drop_request(input int idle_cycles);
      rd = 1'b0;
      wr = 1'b0;
      repeat (idle_cycles) @(negedge clk);
   endtask

   // Called on a falling edge; returns on the falling edge of the done cycle
   task automatic access_and_check(input logic write_op, input logic [word_w-1:0] a,
                                   input logic [word_w-1:0] d, output logic seen_err);
      logic [tag_w-1:0]   t;
      logic [index_w-1:0] idx;
      logic [word_w-2:0]  waddr;
      logic               exp_hit;
      logic               got_done;
      int                 cycles;
      t = a[word_w-1 -: tag_w];
      idx = a[offset_w +: index_w];
      waddr = a[word_w-1:1];
      exp_hit = model_valid[idx] && (model_tag[idx] == t);
      addr = a;
      data_in = d;
      rd = ~write_op;
      wr = write_op;
      cycles = 0;
      got_done = 1'b0;
      seen_err = 1'b0;
      while (!got_done && cycles < done_limit) begin
         @(negedge clk);
         cycles++;
         seen_err = seen_err | err;
         if (done) begin
            got_done = 1'b1;
            compare_bit("stall", 1'b0, stall);
         end else begin
            // Busy until the done cycle
            compare_bit("stall", 1'b1, stall);
         end
      end
      if (!got_done) begin
         errors++;
         $display("Request to address %h got no done within %0d cycles", a, done_limit);
         drop_request(0);
      end else begin
         compare_bit("cache_hit", exp_hit, cache_hit);
         if (!write_op) begin
            compare_word("data_out", model_word(waddr), data_out);
         end
         if (exp_hit) begin
            compare_cycles("hit latency", 2, cycles);
         end
         // Line now belongs to this tag
         model_valid[idx] = 1'b1;
         model_tag[idx] = t;
         if (write_op) begin
            model_mem[waddr] = d;
         end
      end
   endtask

   task automatic check_after_reset();
      logic e;
      @(negedge clk);
      compare_bit("done", 1'b0, done);
      compare_bit("stall", 1'b0, stall);
      compare_bit("cache_hit", 1'b0, cache_hit);
      compare_bit("err", 1'b0, err);
      // Fresh line in zeroed memory
      access_and_check(1'b0, 16'h0040, '0, e);
      drop_request(1);
   endtask

   task automatic check_write_read();
      logic e;
      access_and_check(1'b1, 16'h0122, 16'hbeef, e);
      drop_request(1);
      // Read starts from idle
      access_and_check(1'b0, 16'h0122, '0, e);
      drop_request(1);
   endtask

   task automatic check_line_fill();
      logic [word_w-1:0] base = 16'h0a30;
      logic              e;
      // Distinct words in the line, later evicted to memory
      for (int i = 0; i < words_per_line; i++) begin
         access_and_check(1'b1, base + 16'(2 * i), 16'hc000 + 16'(i * 16'h0111), e);
      end
      // Same index with another tag
      access_and_check(1'b0, base ^ 16'h0800, '0, e);
      // Word 2 misses and refills the whole line
      access_and_check(1'b0, base + 16'd4, '0, e);
      for (int i = 0; i < words_per_line; i++) begin
         if (i != 2) begin
            access_and_check(1'b0, base + 16'(2 * i), '0, e);
         end
      end
      drop_request(1);
   endtask

   task automatic check_dirty_eviction();
      logic [word_w-1:0] addr_a = 16'h3358;
      logic [word_w-1:0] addr_b = 16'h5358;
      logic              e;
      access_and_check(1'b1, addr_a, 16'ha5a1, e);
      // Evicts dirty A
      access_and_check(1'b1, addr_b, 16'h5a5e, e);
      // A only correct if the writeback reached memory
      access_and_check(1'b0, addr_a, '0, e);
      access_and_check(1'b0, addr_b, '0, e);
      drop_request(1);
   endtask

   task automatic run_random_traffic();
      logic [tag_w-1:0]   tags [3] = '{5'h01, 5'h0e, 5'h1b};
      logic [index_w-1:0] idxs [4] = '{8'h10, 8'h11, 8'h7f, 8'hc3};
      logic [word_w-1:0]  a;
      logic [word_w-1:0]  d;
      logic               e;
      int                 r;
      for (int n = 0; n < random_requests; n++) begin
         r = $random(seed);
         // Even offsets only
         a = {tags[r[7:2] % 3], idxs[r[1:0]], r[9:8], 1'b0};
         d = 16'($random(seed));
         access_and_check(r[10], a, d, e);
         // Occasional gap between back to back requests
         if (r[13:11] == 3'd0) begin
            drop_request(1);
         end
      end
      drop_request(1);
   endtask

   task automatic check_error_flag();
      logic e;
      // Odd byte address into a resident line
      access_and_check(1'b0, 16'h0a33, '0, e);
      compare_bit("err on misaligned read", 1'b1, e);
      drop_request(1);
      access_and_check(1'b0, 16'h0a34, '0, e);
      compare_bit("err on aligned read", 1'b0, e);
      drop_request(1);
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      addr = '0;
      data_in = '0;
      rd = 1'b0;
      wr = 1'b0;
      seed = 32'h00f52a53;
      checks = 0;
      errors = 0;
      model_valid = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      check_after_reset();
      check_write_read();
      check_line_fill();
      check_dirty_eviction();
      run_random_traffic();
      check_error_flag();

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // Every request bounded by done_limit plus slack for reset and gaps
   initial begin
      #((num_requests * done_limit + 100) * clk_period);
      $display("Watchdog expired after %0t with %0d errors", $time, errors);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- build.f
verilog/mem_sys_pkg.sv
verilog/cache_array.sv
verilog/four_bank_mem.sv
verilog/cache_ctrl.sv
verilog/mem_system.sv
test/mem_system_tb.sv
